// ==== dac_regs_pkg.sv ====
// register map of the AD5601 controller
// bus widths, word addresses and response codes

`default_nettype none

package dac_regs_pkg;

    ////////////////////
    // bus widths

    localparam int bus_data_width = 32;
    localparam int bus_addr_width = 8;   // byte address
    localparam int bus_be_width   = bus_data_width / 8;

    ////////////////////
    // register map

    // word addresses, byte address is word address times 4
    typedef enum logic [2:0] {
        addr_version_id   = 3'd0,
        addr_num_regs     = 3'd1,
        addr_device_state = 3'd2,
        addr_dac_reg      = 3'd3,
        addr_en_avmm_ctrl = 3'd4,
        total_regs        = 3'd5    // first undefined address
    } reg_addr_t;

    typedef enum logic [1:0] {
        resp_okay        = 2'd0,
        resp_slave_error = 2'd2
    } resp_t;

    localparam logic [15:0] module_version = 16'd1;   // upper half of version word

endpackage

`default_nettype wire

// ==== dac_spi_pkg.sv ====
// AD5601 frame layout
// and states of the transfer sequencer

`default_nettype none

package dac_spi_pkg;

    ////////////////////
    // frame layout

    // one frame per update, MSB first
    // 15:14 power-down mode
    // 13:6  data
    // 5:0   don't care
    localparam int dac_frame_width = 16;
    localparam int dac_data_width  = 8;
    localparam int dac_data_lsb    = 6;

    ////////////////////
    // sequencer

    typedef enum logic [1:0] {
        st_idle              = 2'd0,    // waiting for a load
        st_start_after_reset = 2'd1,    // default frame pending
        st_busy              = 2'd2     // frame on the wire
    } seq_state_t;

endpackage

`default_nettype wire

// ==== dac_avmm_regfile.sv ====
// memory-mapped register slave of the AD5601 controller
// DAC register with byte merge, direct data path and load pulse

`timescale 1ns/1ns
`default_nettype none

module dac_avmm_regfile
    import dac_regs_pkg::*;
    import dac_spi_pkg::*;
#(
    parameter logic [15:0] module_id   = 16'h0000,
    parameter logic [15:0] dac_default = 16'h0000   // mode 15:14, data 13:6
) (
    input  var logic                      clk_ifc,
    input  var logic                      SET_DEFAULT_ON_RESET,

    input  var logic [bus_addr_width-1:0] address,
    input  var logic                      read,
    input  var logic                      write,
    input  var logic [bus_data_width-1:0] writedata,
    input  var logic [bus_be_width-1:0]   byteenable,
    output logic                          waitrequest,
    output logic [bus_data_width-1:0]     readdata,
    output logic                          readdatavalid,
    output logic                          writeresponsevalid,
    output resp_t                         response,

    input  var logic                      en_avmm_ctrl,
    input  var logic [dac_data_width-1:0] dac_data,
    input  var logic                      dac_data_valid,

    output logic                          dac_load,
    output logic [dac_frame_width-1:0]    dac_word
);

    localparam int word_addr_width = bus_addr_width - 2;

    logic [word_addr_width-1:0] word_address;
    logic                       addr_valid;
    logic                       bus_dac_wr;     // bus owns the register
    logic                       direct_wr;      // strobe owns it
    logic [bus_data_width-1:0]  dac_reg;
    logic                       en_mirror;      // read-only copy of en_avmm_ctrl
    logic [bus_data_width-1:0]  read_mux;

    // replace only the enabled byte lanes
    function automatic logic [bus_data_width-1:0] merge_bytes(
        input logic [bus_data_width-1:0] old_word,
        input logic [bus_data_width-1:0] new_word,
        input logic [bus_be_width-1:0]   be
    );
        logic [bus_data_width-1:0] merged;
        merged = old_word;
        for (int i = 0; i < bus_be_width; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////
    // decode

    assign word_address = address[bus_addr_width-1:2];
    assign addr_valid   = word_address < word_addr_width'(total_regs);

    assign bus_dac_wr = write && en_avmm_ctrl
                        && (word_address == word_addr_width'(addr_dac_reg));
    assign direct_wr  = dac_data_valid && !en_avmm_ctrl;

    assign dac_word = dac_reg[dac_frame_width-1:0];   // upper half never reaches the DAC

    always_comb begin
        case (reg_addr_t'(word_address[2:0]))
            addr_version_id:   read_mux = {module_version, module_id};
            addr_num_regs:     read_mux = bus_data_width'(total_regs);
            addr_device_state: read_mux = bus_data_width'(1);   // always ready
            addr_dac_reg:      read_mux = dac_reg;
            addr_en_avmm_ctrl: read_mux = {{(bus_data_width-1){1'b0}}, en_mirror};
            default:           read_mux = '0;
        endcase
    end

    ////////////////////
    // control and DAC register

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            waitrequest        <= 1'b1;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            dac_load           <= 1'b0;
            dac_reg            <= {{(bus_data_width-16){1'b0}}, dac_default};
        end else begin
            waitrequest        <= 1'b0;
            readdatavalid      <= read;
            writeresponsevalid <= write;
            dac_load           <= bus_dac_wr || direct_wr;   // same cycle as new value

            if (bus_dac_wr) begin
                dac_reg <= merge_bytes(dac_reg, writedata, byteenable);
            end else if (direct_wr) begin
                dac_reg[dac_data_lsb +: dac_data_width] <= dac_data;
            end
        end
    end

    // read data and response path
    always_ff @(posedge clk_ifc) begin
        en_mirror <= en_avmm_ctrl;
        if (read || write) begin
            response <= addr_valid ? resp_okay : resp_slave_error;
        end
        if (read) begin
            readdata <= addr_valid ? read_mux : '0;
        end
    end

endmodule

`default_nettype wire

// ==== dac_spi_sequencer.sv ====
// transfer sequencer for the AD5601 controller
// launches frames, merges loads during a frame, owns initdone

`timescale 1ns/1ns
`default_nettype none

module dac_spi_sequencer
    import dac_spi_pkg::*;
#(
    parameter bit write_default_at_reset = 1'b0
) (
    input  var logic                       clk_ifc,
    input  var logic                       SET_DEFAULT_ON_RESET,

    input  var logic                       dac_load,
    input  var logic [dac_frame_width-1:0] dac_word,

    input  var logic                       shift_done,
    input  var logic                       shift_busy,
    output logic                           shift_start,
    output logic [dac_frame_width-1:0]     shift_frame,

    output logic                           dac_data_updated,
    output logic                           initdone
);

    seq_state_t state_q;
    logic       pending_q;   // at least one load since the last launch
    logic       launch;

    // decide whether a frame goes out on the next edge
    always_comb begin
        case (state_q)
            st_idle:              launch = (dac_load || pending_q) && !shift_busy;
            st_start_after_reset: launch = !shift_busy;
            st_busy:              launch = shift_done && (dac_load || pending_q);
            default:              launch = 1'b0;
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state_q          <= write_default_at_reset ? st_start_after_reset : st_idle;
            pending_q        <= 1'b0;
            shift_start      <= 1'b0;
            dac_data_updated <= 1'b0;
        end else begin
            shift_start      <= launch;
            dac_data_updated <= shift_done;   // one pulse per finished frame

            if (launch) begin
                pending_q <= 1'b0;            // latest dac_word covers every earlier load
            end else if (dac_load) begin
                pending_q <= 1'b1;
            end

            case (state_q)
                st_idle, st_start_after_reset: begin
                    if (launch) begin
                        state_q <= st_busy;
                    end
                end
                st_busy: begin
                    if (shift_done && !launch) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // frame payload
    always_ff @(posedge clk_ifc) begin
        if (launch) begin
            shift_frame <= dac_word;
        end
    end

    // done at once, or after the default frame
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            initdone <= 1'b0;
        end else if (!write_default_at_reset || shift_done) begin
            initdone <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dac_spi_shifter.sv ====
// 16-bit SPI serializer for the AD5601
// SCLK divider, bit timing and frame strobe

`timescale 1ns/1ns
`default_nettype none

module dac_spi_shifter
    import dac_spi_pkg::*;
#(
    parameter int sclk_half_period = 2   // clk cycles per SCLK half period
) (
    input  var logic                       clk_ifc,
    input  var logic                       SET_DEFAULT_ON_RESET,

    input  var logic                       shift_start,
    input  var logic [dac_frame_width-1:0] shift_frame,

    output logic                           sclk,
    output logic                           mosi,
    output logic                           sync_n,
    output logic                           shift_busy,
    output logic                           shift_done
);

    localparam int div_width  = $clog2(sclk_half_period) + 1;
    localparam int last_half  = 2 * dac_frame_width - 1;
    localparam int half_width = $clog2(2 * dac_frame_width);

    logic [div_width-1:0]       div_cnt;
    logic [half_width-1:0]      half_cnt;    // SCLK half periods done in this frame
    logic                       busy_q;
    logic [dac_frame_width-1:0] shift_q;

    assign mosi       = shift_q[dac_frame_width-1];   // MSB first
    assign sync_n     = ~busy_q;
    assign shift_busy = busy_q;

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            busy_q     <= 1'b0;
            sclk       <= 1'b1;   // idle high
            shift_done <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= '0;
        end else begin
            shift_done <= 1'b0;
            if (!busy_q) begin
                if (shift_start) begin
                    busy_q   <= 1'b1;
                    shift_q  <= shift_frame;
                    div_cnt  <= '0;
                    half_cnt <= '0;
                end
            end else if (div_cnt == div_width'(sclk_half_period - 1)) begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 1'b1;
                sclk     <= ~sclk;
                if (half_cnt == half_width'(last_half)) begin
                    busy_q     <= 1'b0;   // sync_n up with the last rising edge
                    shift_done <= 1'b1;
                    sclk       <= 1'b1;
                end else if (!sclk) begin
                    shift_q <= shift_q << 1;   // rising edge launches next bit
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dac_ad5601_ctrl.sv ====
// top level of the AD5601 controller
// register slave, transfer sequencer and SPI serializer

`timescale 1ns/1ns
`default_nettype none

module dac_ad5601_ctrl
    import dac_regs_pkg::*;
    import dac_spi_pkg::*;
#(
    parameter logic [15:0] module_id              = 16'h0000,
    parameter logic [15:0] dac_default            = 16'h0000,
    parameter bit          write_default_at_reset = 1'b0,
    parameter int          sclk_half_period       = 2
) (
    input  var logic                      clk_ifc,
    input  var logic                      SET_DEFAULT_ON_RESET,

    // register bus
    input  var logic [bus_addr_width-1:0] address,
    input  var logic                      read,
    input  var logic                      write,
    input  var logic [bus_data_width-1:0] writedata,
    input  var logic [bus_be_width-1:0]   byteenable,
    output logic                          waitrequest,
    output logic [bus_data_width-1:0]     readdata,
    output logic                          readdatavalid,
    output logic                          writeresponsevalid,
    output resp_t                         response,

    // direct data path
    input  var logic                      en_avmm_ctrl,
    input  var logic [dac_data_width-1:0] dac_data,
    input  var logic                      dac_data_valid,
    output logic                          dac_data_updated,
    output logic                          initdone,

    // AD5601 pins
    output logic                          sclk,
    output logic                          mosi,
    output logic                          sync_n
);

    logic                       dac_load;
    logic [dac_frame_width-1:0] dac_word;
    logic                       shift_start;
    logic [dac_frame_width-1:0] shift_frame;
    logic                       shift_done;
    logic                       shift_busy;

    ////////////////////
    // register map and bus

    dac_avmm_regfile #(
        .module_id   (module_id),
        .dac_default (dac_default)
    ) dac_avmm_regfile_i (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .address              (address),
        .read                 (read),
        .write                (write),
        .writedata            (writedata),
        .byteenable           (byteenable),
        .waitrequest          (waitrequest),
        .readdata             (readdata),
        .readdatavalid        (readdatavalid),
        .writeresponsevalid   (writeresponsevalid),
        .response             (response),
        .en_avmm_ctrl         (en_avmm_ctrl),
        .dac_data             (dac_data),
        .dac_data_valid       (dac_data_valid),
        .dac_load             (dac_load),
        .dac_word             (dac_word)
    );

    ////////////////////
    // transfer control

    dac_spi_sequencer #(
        .write_default_at_reset (write_default_at_reset)
    ) dac_spi_sequencer_i (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_load             (dac_load),
        .dac_word             (dac_word),
        .shift_done           (shift_done),
        .shift_busy           (shift_busy),
        .shift_start          (shift_start),
        .shift_frame          (shift_frame),
        .dac_data_updated     (dac_data_updated),
        .initdone             (initdone)
    );

    ////////////////////
    // SPI serializer

    dac_spi_shifter #(
        .sclk_half_period (sclk_half_period)
    ) dac_spi_shifter_i (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .shift_start          (shift_start),
        .shift_frame          (shift_frame),
        .sclk                 (sclk),
        .mosi                 (mosi),
        .sync_n               (sync_n),
        .shift_busy           (shift_busy),
        .shift_done           (shift_done)
    );

endmodule

`default_nettype wire

// ==== dac_ad5601_ctrl_asserts.sv ====
// bound protocol checks for the AD5601 controller
// read latency, initdone, SCLK idle level, waitrequest

`timescale 1ns/1ns
`default_nettype none

module dac_ad5601_ctrl_asserts (
    input var logic clk_ifc,
    input var logic SET_DEFAULT_ON_RESET,
    input var logic read,
    input var logic readdatavalid,
    input var logic waitrequest,
    input var logic initdone,
    input var logic sclk,
    input var logic sync_n
);

    int failures = 0;   // failed checks so far

    read_to_valid: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        read |=> readdatavalid)
        else begin
            $error("readdatavalid did not follow a read by one cycle");
            failures++;
        end

    initdone_sticky: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        $past(initdone) && !$past(SET_DEFAULT_ON_RESET) |-> initdone)
        else begin
            $error("initdone fell outside reset");
            failures++;
        end

    // SCLK idles high between frames
    sclk_idle: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        sync_n |-> sclk)
        else begin
            $error("sclk low while sync_n high");
            failures++;
        end

    no_wait: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        !$past(SET_DEFAULT_ON_RESET) |-> !waitrequest)
        else begin
            $error("waitrequest high outside reset");
            failures++;
        end

endmodule

bind dac_ad5601_ctrl dac_ad5601_ctrl_asserts dac_ad5601_ctrl_asserts_i (.*);

`default_nettype wire

// ==== tb_dac_ad5601_ctrl.sv ====
// testbench for the AD5601 controller
// bus stimulus, SPI frame capture and value checks

`timescale 1ns/1ns
`default_nettype none

module tb_dac_ad5601_ctrl
    import dac_regs_pkg::*;
    import dac_spi_pkg::*;
;

    localparam logic [15:0] module_id   = 16'h5a17;
    localparam logic [15:0] dac_default = 16'hc3c0;
    localparam int          wait_limit  = 400;   // clk cycles per wait

    logic        clk_ifc;
    logic        SET_DEFAULT_ON_RESET;
    logic [7:0]  address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        readdatavalid;
    logic        writeresponsevalid;
    resp_t       response;
    logic        en_avmm_ctrl;
    logic [7:0]  dac_data;
    logic        dac_data_valid;
    logic        dac_data_updated;
    logic        initdone;
    logic        sclk;
    logic        mosi;
    logic        sync_n;

    logic [15:0] frames[$];     // captured SPI words
    logic [15:0] cap_word = '0;
    int          cap_bits = 0;
    int          updates = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dac_ad5601_ctrl #(
        .module_id              (module_id),
        .dac_default            (dac_default),
        .write_default_at_reset (1'b1),
        .sclk_half_period       (2)
    ) dac_ad5601_ctrl_i (.*);

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;
    end

    ////////////////////
    // monitors

    always @(negedge sync_n) cap_bits = 0;

    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            cap_word = {cap_word[14:0], mosi};   // DAC samples on falling SCLK
            cap_bits++;
        end
    end

    always @(posedge sync_n) begin
        if (SET_DEFAULT_ON_RESET === 1'b0) begin
            expect_equal(cap_bits, 16, "bits per frame");
            frames.push_back(cap_word);
        end
    end

    always @(negedge clk_ifc) begin
        if (dac_data_updated === 1'b1) updates++;
    end

    ////////////////////
    // helpers

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [15:0] next_frame();
        if (frames.size() == 0) return 'x;
        return frames.pop_front();
    endfunction

    task automatic bus_access(input bit is_write, input int word_addr, input logic [31:0] data,
                              input logic [3:0] be, output logic [31:0] rdata,
                              output resp_t resp);
        int cnt;
        cnt = 0;
        while (waitrequest !== 1'b0 && cnt < wait_limit) begin
            @(negedge clk_ifc);
            cnt++;
        end
        if (waitrequest !== 1'b0) begin
            $display("timeout: waitrequest stayed high");
            errors++;
        end
        address    = 8'(word_addr * 4);   // byte address
        writedata  = data;
        byteenable = be;
        read       = !is_write;
        write      = is_write;
        @(negedge clk_ifc);
        read  = 1'b0;
        write = 1'b0;
        cnt   = 0;
        while ((is_write ? writeresponsevalid : readdatavalid) !== 1'b1 && cnt < wait_limit) begin
            @(negedge clk_ifc);
            cnt++;
        end
        if ((is_write ? writeresponsevalid : readdatavalid) !== 1'b1) begin
            $display("timeout: the bus access got no response");
            errors++;
        end else begin
            expect_equal(cnt, 0, "extra cycles before the bus response");   // one cycle only
        end
        rdata = readdata;
        resp  = response;
    endtask

    task automatic check_read(input int word_addr, input logic [31:0] exp, input string what);
        logic [31:0] rdata;
        resp_t       resp;
        bus_access(1'b0, word_addr, '0, '0, rdata, resp);
        expect_equal(rdata, exp, what);
        expect_equal(resp, resp_okay, {what, " response"});
    endtask

    task automatic check_write(input int word_addr, input logic [31:0] data,
                               input logic [3:0] be, input resp_t exp_resp, input string what);
        logic [31:0] rdata;
        resp_t       resp;
        bus_access(1'b1, word_addr, data, be, rdata, resp);
        expect_equal(resp, exp_resp, what);
    endtask

    task automatic wait_frames(input int n);
        int cnt;
        cnt = 0;
        while (frames.size() < n && cnt < wait_limit) begin
            @(negedge clk_ifc);
            cnt++;
        end
        if (frames.size() < n) begin
            $display("timeout: fewer than %0d SPI frames arrived", n);
            errors++;
        end
    endtask

    task automatic wait_updates(input int target);
        int cnt;
        cnt = 0;
        while (updates < target && cnt < wait_limit) begin
            @(negedge clk_ifc);
            cnt++;
        end
        if (updates < target) begin
            $display("timeout: dac_data_updated did not pulse");
            errors++;
        end
    endtask

    task automatic wait_frame_start();
        int cnt;
        cnt = 0;
        while (sync_n !== 1'b0 && cnt < wait_limit) begin
            @(negedge clk_ifc);
            cnt++;
        end
        if (sync_n !== 1'b0) begin
            $display("timeout: sync_n never fell");
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    ////////////////////
    // stimulus

    initial begin
        logic [31:0] model;
        logic [31:0] data;
        logic [31:0] last;
        logic [31:0] mask;
        logic [31:0] rdata;
        logic [3:0]  be;
        resp_t       resp;
        int          base;
        int          base_upd;
        void'($urandom(32'hcfea));
        SET_DEFAULT_ON_RESET = 1'b1;
        address        = '0;
        read           = 1'b0;
        write          = 1'b0;
        writedata      = '0;
        byteenable     = '0;
        en_avmm_ctrl   = 1'b1;
        dac_data       = '0;
        dac_data_valid = 1'b0;
        repeat (3) @(posedge clk_ifc);   // three clock edges in reset
        @(negedge clk_ifc);
        SET_DEFAULT_ON_RESET = 1'b0;
        model = {16'h0000, dac_default};

        // default frame and constant registers
        base = errors;
        wait_frames(1);
        wait_updates(1);
        expect_equal(next_frame(), dac_default, "default frame");
        expect_equal(initdone, 1'b1, "initdone after default frame");
        check_read(addr_version_id, {module_version, module_id}, "version word");
        check_read(addr_num_regs, 5, "register count");
        check_read(addr_device_state, 1, "device state");
        check_read(addr_en_avmm_ctrl, 1, "control select mirror");
        finish_test("reset and default frame", base);

        base     = errors;
        base_upd = updates;
        data     = $urandom;
        be       = 4'($urandom);
        for (int i = 0; i < 4; i++) mask[8*i +: 8] = {8{be[i]}};
        model = (model & ~mask) | (data & mask);
        check_write(addr_dac_reg, data, be, resp_okay, "DAC write response");
        check_read(addr_dac_reg, model, "DAC readback");
        wait_frames(1);
        expect_equal(next_frame(), model[15:0], "frame after bus write");
        wait_updates(base_upd + 1);
        finish_test("bus write under bus control", base);

        // strobe owns the register now
        base           = errors;
        base_upd       = updates;
        en_avmm_ctrl   = 1'b0;
        dac_data       = 8'($urandom);
        dac_data_valid = 1'b1;
        @(negedge clk_ifc);
        dac_data_valid = 1'b0;
        model[dac_data_lsb +: dac_data_width] = dac_data;
        wait_frames(1);
        expect_equal(next_frame(), model[15:0], "frame after direct data");
        wait_updates(base_upd + 1);
        check_read(addr_en_avmm_ctrl, 0, "control select mirror");
        check_write(addr_dac_reg, $urandom, 4'hf, resp_okay, "ignored DAC write response");
        check_read(addr_dac_reg, model, "DAC readback after ignored write");
        repeat (100) @(negedge clk_ifc);
        expect_equal(frames.size(), 0, "frames after ignored write");
        en_avmm_ctrl = 1'b1;
        finish_test("direct data path", base);

        base     = errors;
        base_upd = updates;
        data     = $urandom;
        last     = $urandom;
        check_write(addr_dac_reg, data, 4'hf, resp_okay, "first write response");
        wait_frame_start();
        check_write(addr_dac_reg, $urandom, 4'hf, resp_okay, "second write response");
        check_write(addr_dac_reg, last, 4'hf, resp_okay, "third write response");
        model = last;
        wait_frames(2);
        wait_updates(base_upd + 2);
        repeat (100) @(negedge clk_ifc);
        expect_equal(frames.size(), 2, "frames after merged writes");
        expect_equal(next_frame(), data[15:0], "first frame");
        expect_equal(next_frame(), last[15:0], "merged frame");
        frames.delete();
        check_read(addr_dac_reg, model, "DAC readback after merge");
        finish_test("merging under back-pressure", base);

        // addresses past the map
        base = errors;
        bus_access(1'b0, 5, '0, '0, rdata, resp);
        expect_equal(resp, resp_slave_error, "read response at address 5");
        bus_access(1'b0, 7, '0, '0, rdata, resp);
        expect_equal(resp, resp_slave_error, "read response at address 7");
        check_write(5, $urandom, 4'hf, resp_slave_error, "write response at address 5");
        check_write(7, $urandom, 4'hf, resp_slave_error, "write response at address 7");
        check_read(addr_dac_reg, model, "DAC readback after undefined access");
        check_read(addr_version_id, {module_version, module_id}, "version word");
        repeat (100) @(negedge clk_ifc);
        expect_equal(frames.size(), 0, "frames after undefined access");
        finish_test("undefined address", base);

        errors += dac_ad5601_ctrl_i.dac_ad5601_ctrl_asserts_i.failures;
        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
dac_regs_pkg.sv
dac_spi_pkg.sv
dac_avmm_regfile.sv
dac_spi_sequencer.sv
dac_spi_shifter.sv
dac_ad5601_ctrl.sv
dac_ad5601_ctrl_asserts.sv
tb_dac_ad5601_ctrl.sv
